// ==== hdl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // Operation selected from func3
    typedef enum logic [1:0] {
        CSR_OP_RW      = 2'd0,
        CSR_OP_RS      = 2'd1,
        CSR_OP_RC      = 2'd2,
        CSR_OP_ILLEGAL = 2'd3
    } csr_op_e;

    // Instruction as sent by the host
    typedef struct packed {
        logic [2:0]  func3;
        logic [11:0] addr;
        logic [31:0] rs1_data;
        logic [4:0]  imm;
    } csr_instr_t;

    typedef struct packed {
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] operand;  // Already selected between rs1 and imm
    } csr_cmd_t;

    typedef struct packed {
        logic [31:0] data;     // Old CSR value
        logic        illegal;
    } csr_rsp_t;

    // User counters, read only
    localparam logic [11:0] CSR_CYCLE     = 12'hC00;
    localparam logic [11:0] CSR_TIME      = 12'hC01;
    localparam logic [11:0] CSR_INSTRET   = 12'hC02;
    localparam logic [11:0] CSR_CYCLEH    = 12'hC80;
    localparam logic [11:0] CSR_TIMEH     = 12'hC81;
    localparam logic [11:0] CSR_INSTRETH  = 12'hC82;

    // Machine information
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_MIMPID    = 12'hF13;

    // Machine trap setup
    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MSTATUSH  = 12'h310;
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;

    // Machine trap handling
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MTVAL     = 12'h343;
    localparam logic [11:0] CSR_MIP       = 12'h344;

    // Machine counters, writable
    localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

    localparam logic [31:0] MISA_VALUE    = 32'h4000_0100;  // RV32I
    localparam logic [31:0] MARCHID_VALUE = 32'h0000_2EF8;
    localparam logic [31:0] MIMPID_VALUE  = 32'h0000_0001;

endpackage

`default_nettype wire

// ==== hdl/csr_cmd_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_cmd_decoder (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               in_req,
    output logic                    in_ack,
    input  wire csr_pkg::csr_instr_t in_instr,
    output logic                    push,
    output csr_pkg::csr_cmd_t       push_cmd,
    input  wire logic               full
);

    typedef enum logic {
        DEC_IDLE,
        DEC_ACK
    } dec_state_e;

    dec_state_e        state;
    csr_pkg::csr_cmd_t dec_cmd;

    // func3[2] picks the immediate form, func3[1:0] the operation
    always_comb begin
        dec_cmd.addr = in_instr.addr;
        if (in_instr.func3[2]) begin
            dec_cmd.operand = {27'd0, in_instr.imm};
        end else begin
            dec_cmd.operand = in_instr.rs1_data;
        end
        case (in_instr.func3[1:0])
            2'b01:   dec_cmd.op = csr_pkg::CSR_OP_RW;
            2'b10:   dec_cmd.op = csr_pkg::CSR_OP_RS;
            2'b11:   dec_cmd.op = csr_pkg::CSR_OP_RC;
            default: dec_cmd.op = csr_pkg::CSR_OP_ILLEGAL;
        endcase
        // 000 and 100 carry no operand
        if (dec_cmd.op == csr_pkg::CSR_OP_ILLEGAL) begin
            dec_cmd.operand = 32'd0;
        end
    end

    // Handshake FSM, push and ack go high together
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DEC_IDLE;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                DEC_IDLE: begin
                    if (in_req && !full) begin
                        state <= DEC_ACK;
                        push  <= 1'b1;
                    end
                end
                DEC_ACK: begin
                    if (!in_req) begin
                        state <= DEC_IDLE;  // Ack drops on the next edge
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // Host may change in_instr once it sees the ack, so hold a copy
    always_ff @(posedge clk) begin
        if (state == DEC_IDLE && in_req && !full) begin
            push_cmd <= dec_cmd;
        end
    end

    assign in_ack = (state == DEC_ACK);

endmodule

`default_nettype wire

// ==== hdl/csr_cmd_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              push,
    input  wire csr_pkg::csr_cmd_t push_cmd,
    output logic                   full,
    input  wire logic              pop,
    output csr_pkg::csr_cmd_t      head_cmd,
    output logic                   empty
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    csr_pkg::csr_cmd_t mem [FIFO_DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              do_push;
    logic              do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == CW'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign head_cmd = mem[rd_ptr];  // Show-ahead

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/csr_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_file #(
    parameter int TIME_DIV = 4
) (
    input  wire logic              clk,
    input  wire logic              reset,
    output logic                   pop,
    input  wire csr_pkg::csr_cmd_t head_cmd,
    input  wire logic              empty,
    output logic                   rsp_req,
    input  wire logic              rsp_ack,
    output csr_pkg::csr_rsp_t      rsp
);

    localparam int PW = (TIME_DIV > 1) ? $clog2(TIME_DIV) : 1;

    typedef enum logic [1:0] {
        CF_IDLE,
        CF_REQ,
        CF_WAIT
    } cf_state_e;

    cf_state_e     state;
    logic [31:0]   mtvec, mscratch, mepc, mcause, mtval;
    logic [63:0]   mcycle, minstret, time_cnt;
    logic [PW-1:0] presc;
    logic          time_tick;
    logic [31:0]   old_val;
    logic [31:0]   new_val;
    logic          known;
    logic          read_only;
    logic          illegal;
    logic          wr_en;
    logic          retire;

    assign pop       = (state == CF_IDLE) && !empty;  // Execute at the pop edge
    assign retire    = (state == CF_REQ) && rsp_ack;
    assign rsp_req   = (state == CF_REQ);
    assign time_tick = (presc == PW'(TIME_DIV - 1));

    // Read side, old value of the head command's CSR
    always_comb begin
        known   = 1'b1;
        old_val = 32'd0;
        case (head_cmd.addr)
            csr_pkg::CSR_CYCLE,    csr_pkg::CSR_MCYCLE:    old_val = mcycle[31:0];
            csr_pkg::CSR_CYCLEH,   csr_pkg::CSR_MCYCLEH:   old_val = mcycle[63:32];
            csr_pkg::CSR_INSTRET,  csr_pkg::CSR_MINSTRET:  old_val = minstret[31:0];
            csr_pkg::CSR_INSTRETH, csr_pkg::CSR_MINSTRETH: old_val = minstret[63:32];
            csr_pkg::CSR_TIME:     old_val = time_cnt[31:0];
            csr_pkg::CSR_TIMEH:    old_val = time_cnt[63:32];
            csr_pkg::CSR_MARCHID:  old_val = csr_pkg::MARCHID_VALUE;
            csr_pkg::CSR_MIMPID:   old_val = csr_pkg::MIMPID_VALUE;
            csr_pkg::CSR_MISA:     old_val = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MTVEC:    old_val = mtvec;
            csr_pkg::CSR_MSCRATCH: old_val = mscratch;
            csr_pkg::CSR_MEPC:     old_val = mepc;
            csr_pkg::CSR_MCAUSE:   old_val = mcause;
            csr_pkg::CSR_MTVAL:    old_val = mtval;
            // Hardwired to zero, writes dropped
            csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MSTATUSH,
            csr_pkg::CSR_MIE, csr_pkg::CSR_MIP: old_val = 32'd0;
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        read_only = (head_cmd.addr[11:10] == 2'b11) || (head_cmd.addr == csr_pkg::CSR_MISA);
        illegal   = (head_cmd.op == csr_pkg::CSR_OP_ILLEGAL) || !known
                    || (read_only && head_cmd.op == csr_pkg::CSR_OP_RW);
        case (head_cmd.op)
            csr_pkg::CSR_OP_RS: new_val = old_val | head_cmd.operand;
            csr_pkg::CSR_OP_RC: new_val = old_val & ~head_cmd.operand;
            default:            new_val = head_cmd.operand;
        endcase
        // RS and RC on read-only CSRs fall through as plain reads
        wr_en = pop && !illegal && !read_only;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtvec    <= 32'd0;
            mscratch <= 32'd0;
            mepc     <= 32'd0;
            mcause   <= 32'd0;
            mtval    <= 32'd0;
        end else if (wr_en) begin
            case (head_cmd.addr)
                csr_pkg::CSR_MTVEC:    mtvec    <= new_val;
                csr_pkg::CSR_MSCRATCH: mscratch <= new_val;
                csr_pkg::CSR_MEPC:     mepc     <= {new_val[31:2], 2'b00};  // Word aligned
                csr_pkg::CSR_MCAUSE:   mcause   <= new_val;
                csr_pkg::CSR_MTVAL:    mtval    <= new_val;
                default: ;
            endcase
        end
    end

    // Counters, a write to one half wins over that cycle's increment
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= 64'd0;
            minstret <= 64'd0;
            time_cnt <= 64'd0;
            presc    <= '0;
        end else begin
            if (wr_en && head_cmd.addr == csr_pkg::CSR_MCYCLE) begin
                mcycle <= {mcycle[63:32], new_val};
            end else if (wr_en && head_cmd.addr == csr_pkg::CSR_MCYCLEH) begin
                mcycle <= {new_val, mcycle[31:0]};
            end else begin
                mcycle <= mcycle + 64'd1;
            end

            if (wr_en && head_cmd.addr == csr_pkg::CSR_MINSTRET) begin
                minstret <= {minstret[63:32], new_val};
            end else if (wr_en && head_cmd.addr == csr_pkg::CSR_MINSTRETH) begin
                minstret <= {new_val, minstret[31:0]};
            end else if (retire) begin
                minstret <= minstret + 64'd1;  // Completed commands stand in for retires
            end

            presc <= time_tick ? '0 : presc + 1'b1;
            if (time_tick) begin
                time_cnt <= time_cnt + 64'd1;
            end
        end
    end

    // Response FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CF_IDLE;
        end else begin
            case (state)
                CF_IDLE: if (pop) state <= CF_REQ;
                CF_REQ:  if (rsp_ack) state <= CF_WAIT;
                CF_WAIT: if (!rsp_ack) state <= CF_IDLE;  // Ack must drop first
                default: state <= CF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rsp.data    <= illegal ? 32'd0 : old_val;
            rsp.illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/csr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int TIME_DIV   = 4
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                in_req,
    output logic                     in_ack,
    input  wire csr_pkg::csr_instr_t in_instr,
    output logic                     rsp_req,
    input  wire logic                rsp_ack,
    output csr_pkg::csr_rsp_t        rsp
);

    // Decoder to FIFO
    logic              push;
    csr_pkg::csr_cmd_t push_cmd;
    logic              full;

    // FIFO to CSR file
    logic              pop;
    csr_pkg::csr_cmd_t head_cmd;
    logic              empty;

    csr_cmd_decoder u_decoder (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_instr (in_instr),
        .push     (push),
        .push_cmd (push_cmd),
        .full     (full)
    );

    csr_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (push),
        .push_cmd (push_cmd),
        .full     (full),
        .pop      (pop),
        .head_cmd (head_cmd),
        .empty    (empty)
    );

    csr_file #(
        .TIME_DIV (TIME_DIV)
    ) u_csr_file (
        .clk      (clk),
        .reset    (reset),
        .pop      (pop),
        .head_cmd (head_cmd),
        .empty    (empty),
        .rsp_req  (rsp_req),
        .rsp_ack  (rsp_ack),
        .rsp      (rsp)
    );

endmodule

`default_nettype wire

// ==== sim/csr_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_properties (
    input wire logic              clk,
    input wire logic              reset,
    input wire logic              in_req,
    input wire logic              in_ack,
    input wire logic              push,
    input wire logic              full,
    input wire logic              rsp_req,
    input wire logic              rsp_ack,
    input wire csr_pkg::csr_rsp_t rsp
);

    int fail_count = 0;

    // Ack follows a request seen on the previous edge
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
        else begin
            fail_count++;
            $error("in_ack rose without in_req");
        end

    rsp_held: assert property (@(posedge clk) disable iff (reset)
        rsp_req && !rsp_ack |=> rsp_req && $stable(rsp))
        else begin
            fail_count++;
            $error("rsp_req or rsp changed before rsp_ack");
        end

    rsp_waits_ack_low: assert property (@(posedge clk) disable iff (reset)
        !rsp_req && rsp_ack |=> !rsp_req)
        else begin
            fail_count++;
            $error("rsp_req rose while rsp_ack still high");
        end

    push_not_full: assert property (@(posedge clk) disable iff (reset)
        push |-> !full)
        else begin
            fail_count++;
            $error("push while FIFO full");
        end

endmodule

bind csr_top csr_properties u_props (
    .clk     (clk),
    .reset   (reset),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .push    (push),   // Internal decoder to FIFO wires
    .full    (full),
    .rsp_req (rsp_req),
    .rsp_ack (rsp_ack),
    .rsp     (rsp)
);

`default_nettype wire

// ==== sim/csr_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_tb;

    localparam int TIME_DIV = 4;
    localparam int NUM_CMDS = 66;  // Sum of all commands sent below

    typedef enum logic [1:0] {
        KIND_EXACT,
        KIND_TIME,
        KIND_CYCLE,
        KIND_ANY
    } check_kind_e;

    typedef struct packed {
        check_kind_e       kind;
        logic [11:0]       addr;
        csr_pkg::csr_rsp_t rsp;
    } expect_t;

    logic                clk;
    logic                reset;
    logic                in_req;
    logic                in_ack;
    csr_pkg::csr_instr_t in_instr;
    logic                rsp_req;
    logic                rsp_ack;
    csr_pkg::csr_rsp_t   rsp;

    logic [31:0] lfsr = 32'h14f3_f484;
    expect_t     exp_q[$];
    int          errors = 0;
    int          responses = 0;
    logic [31:0] last_time = 32'd0;
    logic [31:0] last_cycle = 32'd0;

    // Reference CSR state
    logic [31:0] m_mtvec = 32'd0;
    logic [31:0] m_mscratch = 32'd0;
    logic [31:0] m_mepc = 32'd0;
    logic [31:0] m_mcause = 32'd0;
    logic [31:0] m_mtval = 32'd0;
    logic [63:0] m_minstret = 64'd0;

    csr_top #(
        .FIFO_DEPTH (4),
        .TIME_DIV   (TIME_DIV)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_instr (in_instr),
        .rsp_req  (rsp_req),
        .rsp_ack  (rsp_ack),
        .rsp      (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            lfsr_step = (s >> 1) ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
        end else begin
            lfsr_step = s >> 1;
        end
    endfunction

    task automatic random_bits(input int n, output logic [31:0] val);
        val = 32'd0;
        for (int k = 0; k < n; k++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Expected response and CSR update for one instruction
    task automatic model_cmd(input logic [2:0] func3, input logic [11:0] addr,
                             input logic [31:0] rs1, input logic [4:0] imm,
                             output expect_t e);
        logic [31:0] operand;
        logic [31:0] old;
        logic [31:0] nv;
        logic        known;
        logic        ro;
        logic        bad;
        check_kind_e kind;
        operand = func3[2] ? {27'd0, imm} : rs1;
        kind    = KIND_EXACT;
        known   = 1'b1;
        old     = 32'd0;
        case (addr)
            csr_pkg::CSR_MTVEC:    old = m_mtvec;
            csr_pkg::CSR_MSCRATCH: old = m_mscratch;
            csr_pkg::CSR_MEPC:     old = m_mepc;
            csr_pkg::CSR_MCAUSE:   old = m_mcause;
            csr_pkg::CSR_MTVAL:    old = m_mtval;
            csr_pkg::CSR_MINSTRET, csr_pkg::CSR_INSTRET:   old = m_minstret[31:0];
            csr_pkg::CSR_MINSTRETH, csr_pkg::CSR_INSTRETH: old = m_minstret[63:32];
            csr_pkg::CSR_CYCLE, csr_pkg::CSR_MCYCLE:       kind = KIND_CYCLE;
            csr_pkg::CSR_TIME:                             kind = KIND_TIME;
            csr_pkg::CSR_CYCLEH, csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_TIMEH: kind = KIND_ANY;
            csr_pkg::CSR_MISA:     old = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MARCHID:  old = csr_pkg::MARCHID_VALUE;
            csr_pkg::CSR_MIMPID:   old = csr_pkg::MIMPID_VALUE;
            csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MSTATUSH,
            csr_pkg::CSR_MIE, csr_pkg::CSR_MIP: old = 32'd0;
            default: known = 1'b0;
        endcase
        ro  = (addr[11:10] == 2'b11) || (addr == csr_pkg::CSR_MISA);
        bad = (func3[1:0] == 2'b00) || !known || (ro && func3[1:0] == 2'b01);
        case (func3[1:0])
            2'b10:   nv = old | operand;
            2'b11:   nv = old & ~operand;
            default: nv = operand;
        endcase
        if (!bad && !ro) begin
            case (addr)
                csr_pkg::CSR_MTVEC:     m_mtvec = nv;
                csr_pkg::CSR_MSCRATCH:  m_mscratch = nv;
                csr_pkg::CSR_MEPC:      m_mepc = {nv[31:2], 2'b00};
                csr_pkg::CSR_MCAUSE:    m_mcause = nv;
                csr_pkg::CSR_MTVAL:     m_mtval = nv;
                csr_pkg::CSR_MINSTRET:  m_minstret[31:0] = nv;
                csr_pkg::CSR_MINSTRETH: m_minstret[63:32] = nv;
                default: ;
            endcase
        end
        m_minstret      = m_minstret + 64'd1;  // Every response retires
        e.kind          = bad ? KIND_EXACT : kind;
        e.addr          = addr;
        e.rsp.data      = bad ? 32'd0 : old;
        e.rsp.illegal   = bad;
    endtask

    task automatic send_cmd(input logic [2:0] func3, input logic [11:0] addr,
                            input logic [31:0] rs1, input logic [4:0] imm);
        expect_t e;
        model_cmd(func3, addr, rs1, imm, e);
        exp_q.push_back(e);
        in_instr.func3    = func3;
        in_instr.addr     = addr;
        in_instr.rs1_data = rs1;
        in_instr.imm      = imm;
        in_req            = 1'b1;
        do @(negedge clk); while (!in_ack);
        in_req = 1'b0;
        do @(negedge clk); while (in_ack);
    endtask

    task automatic read_csr(input logic [11:0] addr);
        send_cmd(3'b010, addr, 32'd0, 5'd0);  // Set with zero
    endtask

    task automatic report_mismatch(input expect_t e, input string what);
        errors++;
        $display("Error at %0t ns: CSR 0x%03h %s, got data %h illegal %b, expected %h %b",
                 $time, e.addr, what, rsp.data, rsp.illegal, e.rsp.data, e.rsp.illegal);
    endtask

    task automatic check_response();
        expect_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("A response arrived at %0t ns with no command outstanding", $time);
        end else begin
            e = exp_q.pop_front();
            case (e.kind)
                KIND_EXACT: assert (rsp == e.rsp) else report_mismatch(e, "wrong response");
                KIND_TIME: begin
                    assert (!rsp.illegal) else report_mismatch(e, "time read illegal");
                    last_time = rsp.data;
                end
                KIND_CYCLE: begin
                    assert (!rsp.illegal && rsp.data > last_cycle)
                        else report_mismatch(e, "cycle count did not increase");
                    assert (last_time <= rsp.data / TIME_DIV)
                        else report_mismatch(e, "time ahead of cycle count");
                    last_cycle = rsp.data;
                end
                default: assert (!rsp.illegal) else report_mismatch(e, "counter read illegal");
            endcase
        end
        responses++;
    endtask

    // Host side of the response port with random back-pressure
    initial begin : responder
        logic [31:0] delay;
        logic [31:0] hold;
        wait (reset == 1'b0);
        forever begin
            @(negedge clk);
            if (rsp_req) begin
                check_response();
                random_bits(2, delay);
                repeat (delay) @(negedge clk);
                rsp_ack = 1'b1;
                do @(negedge clk); while (rsp_req);
                random_bits(1, hold);
                repeat (hold) @(negedge clk);  // Ack may linger after rsp_req drops
                rsp_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_CMDS * 40) @(posedge clk);
        $display("Timeout after %0d clock cycles, responses stopped arriving", NUM_CMDS * 40);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [11:0] rw_addrs [4];
        logic [11:0] burst_addrs [8];
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] f;
        rw_addrs    = '{csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MTVEC,
                        csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL};
        burst_addrs = '{csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MTVEC, csr_pkg::CSR_MCAUSE,
                        csr_pkg::CSR_MTVAL, csr_pkg::CSR_MEPC, csr_pkg::CSR_MINSTRET,
                        csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MISA};
        reset    = 1'b1;
        in_req   = 1'b0;
        in_instr = '0;
        rsp_ack  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 4; i++) begin
            random_bits(32, r);
            send_cmd(3'b001, rw_addrs[i], r, 5'd0);
            random_bits(32, r);
            send_cmd(3'b010, rw_addrs[i], r, 5'd0);
            random_bits(32, r);
            send_cmd(3'b011, rw_addrs[i], r, 5'd0);
            read_csr(rw_addrs[i]);
        end

        // Immediate forms get a noisy rs1 that must be ignored
        for (int j = 5; j < 8; j++) begin
            random_bits(32, r);
            random_bits(5, r2);
            send_cmd(j[2:0], csr_pkg::CSR_MSCRATCH, r, r2[4:0]);
        end
        read_csr(csr_pkg::CSR_MSCRATCH);

        random_bits(32, r);
        send_cmd(3'b001, csr_pkg::CSR_MEPC, r | 32'h3, 5'd0);
        read_csr(csr_pkg::CSR_MEPC);
        read_csr(csr_pkg::CSR_MISA);
        read_csr(csr_pkg::CSR_MARCHID);
        read_csr(csr_pkg::CSR_MIMPID);
        random_bits(32, r);
        send_cmd(3'b001, csr_pkg::CSR_MSTATUS, r, 5'd0);
        read_csr(csr_pkg::CSR_MSTATUS);
        send_cmd(3'b001, csr_pkg::CSR_MIE, ~r, 5'd0);
        read_csr(csr_pkg::CSR_MIE);
        send_cmd(3'b001, csr_pkg::CSR_MIP, r, 5'd0);
        read_csr(csr_pkg::CSR_MIP);

        random_bits(32, r);
        send_cmd(3'b000, csr_pkg::CSR_MSCRATCH, r, 5'd0);
        send_cmd(3'b100, csr_pkg::CSR_MSCRATCH, r, 5'h1f);
        send_cmd(3'b001, 12'h7C0, r, 5'd0);  // Unknown address
        send_cmd(3'b001, csr_pkg::CSR_CYCLE, r, 5'd0);
        send_cmd(3'b001, csr_pkg::CSR_MISA, r, 5'd0);
        read_csr(csr_pkg::CSR_MSCRATCH);
        read_csr(csr_pkg::CSR_MISA);

        read_csr(csr_pkg::CSR_MINSTRET);
        send_cmd(3'b001, csr_pkg::CSR_MINSTRET, 32'd1000, 5'd0);
        read_csr(csr_pkg::CSR_MINSTRET);
        read_csr(csr_pkg::CSR_TIME);
        read_csr(csr_pkg::CSR_CYCLE);
        read_csr(csr_pkg::CSR_MCYCLE);
        read_csr(csr_pkg::CSR_MCYCLE);
        read_csr(csr_pkg::CSR_CYCLEH);

        // Burst, random func3 includes the illegal codes
        for (int k = 0; k < 20; k++) begin
            random_bits(3, r2);
            random_bits(3, f);
            random_bits(32, r);
            send_cmd(f[2:0], burst_addrs[r2[2:0]], r, r[4:0] ^ 5'h15);
        end

        while (exp_q.size() != 0) @(negedge clk);
        wait (!rsp_req && !rsp_ack);  // Last response handshake complete
        assert (responses == NUM_CMDS) else begin
            errors++;
            $display("Error at %0t ns: %0d responses, %0d expected", $time, responses, NUM_CMDS);
        end
        $display("Done: %0d responses, %0d check errors, %0d property failures",
                 responses, errors, DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/csr_pkg.sv
hdl/csr_cmd_decoder.sv
hdl/csr_cmd_fifo.sv
hdl/csr_file.sv
hdl/csr_top.sv
sim/csr_properties.sv
sim/csr_tb.sv

// ==== Bender.yml ====
package:
  name: csr_subsystem

sources:
  - hdl/csr_pkg.sv
  - hdl/csr_cmd_decoder.sv
  - hdl/csr_cmd_fifo.sv
  - hdl/csr_file.sv
  - hdl/csr_top.sv
  - target: simulation
    files:
      - sim/csr_properties.sv
      - sim/csr_tb.sv
